//--- all.f
hdl/frontend_pkg.sv
hdl/rv_isa_pkg.sv
hdl/fetch_slot_if.sv
hdl/fetch_buffer.sv
hdl/rvc_expander.sv
hdl/issue_register.sv
hdl/fetch_frontend.sv
bench/fetch_frontend_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module fetch_frontend_tb -f all.f \
  -Mdir obj_dir -o fetch_frontend_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetch_frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0

//--- bench/fetch_frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_tb;

  typedef struct packed {
    logic fetch_valid;
    logic [31:0] fetch_pc;
    logic [63:0] fetch_data;
    logic clear;
    logic issue_stall;
    logic exp_stall;
    logic [1:0] exp_valid;
    logic [1:0][31:0] exp_pc;
    logic [1:0][31:0] exp_instr;
    logic [1:0] exp_comp;
    logic [1:0] exp_ill;
  } row_t;

  logic clock;
  logic reset;
  logic clear;
  logic fetch_valid;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_data;
  logic fetch_stall;
  logic issue_stall;
  logic issue_valid0;
  logic issue_valid1;
  logic [31:0] issue_pc0;
  logic [31:0] issue_pc1;
  logic [31:0] issue_instr0;
  logic [31:0] issue_instr1;
  logic issue_compressed0;
  logic issue_compressed1;
  logic issue_illegal0;
  logic issue_illegal1;

  row_t rows [$];
  row_t cur;
  logic [31:0] lfsr_state;
  int cycles = 0;

  fetch_frontend dut0 (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .fetch_stall(fetch_stall),
    .issue_stall(issue_stall),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_compressed0(issue_compressed0),
    .issue_compressed1(issue_compressed1),
    .issue_illegal0(issue_illegal0),
    .issue_illegal1(issue_illegal1)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [5:0] random_imm6();
    logic [5:0] v;
    v = '0;
    for (int k = 0; k < 6; k++) begin
      v = {v[4:0], lfsr_step()};
    end
    return v;
  endfunction

  // Compressed encoders, CI and CR formats
  function automatic logic [15:0] c_ci(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [5:0] imm);
    return {f3, imm[5], rd, imm[4:0], 2'b01};
  endfunction

  function automatic logic [15:0] c_cr(input logic bit12, input logic [4:0] rd,
                                       input logic [4:0] rs2);
    return {3'b100, bit12, rd, rs2, 2'b10};
  endfunction

  // Base ISA encoders for the expected words
  function automatic logic [31:0] i_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] r_add(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [4:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] u_lui(input logic [5:0] imm, input logic [4:0] rd);
    return {{14{imm[5]}}, imm, rd, 7'b0110111};
  endfunction

  function automatic logic [11:0] sext12(input logic [5:0] v);
    return {{6{v[5]}}, v};
  endfunction

  task automatic begin_row(input logic fv, input logic [31:0] pc, input logic [63:0] data,
                           input logic clr, input logic stall, input logic fs);
    cur.fetch_valid = fv;
    cur.fetch_pc = pc;
    cur.fetch_data = data;
    cur.clear = clr;
    cur.issue_stall = stall;
    cur.exp_stall = fs;
    // Outputs hold under issue_stall unless cleared
    if (clr || !stall) begin
      cur.exp_valid = '0;
      cur.exp_pc = '0;
      cur.exp_instr = {i_addi(12'd0, 5'd0, 5'd0), i_addi(12'd0, 5'd0, 5'd0)};
      cur.exp_comp = '0;
      cur.exp_ill = '0;
    end
  endtask

  task automatic expect_slot(input int s, input logic [31:0] pc, input logic [31:0] instr,
                             input logic comp, input logic ill);
    cur.exp_valid[s] = 1'b1;
    cur.exp_pc[s] = pc;
    cur.exp_instr[s] = instr;
    cur.exp_comp[s] = comp;
    cur.exp_ill[s] = ill;
  endtask

  task automatic build_table();
    logic [31:0] addi32;
    logic [31:0] add32;
    logic [31:0] y32;
    logic [31:0] z32;
    logic [31:0] nop;
    logic [63:0] data_n;
    logic [5:0] imm1;
    logic [5:0] imm2;
    logic [5:0] imm3;
    logic [5:0] imm4;
    logic [5:0] imm5;
    logic [5:0] imm6;
    logic [5:0] imm7;
    addi32 = i_addi(12'd100, 5'd6, 5'd5);
    add32 = r_add(5'd9, 5'd8, 5'd7);
    y32 = {20'habcde, 5'd20, 7'b0110111};
    z32 = i_addi(12'h800, 5'd27, 5'd28);
    nop = i_addi(12'd0, 5'd0, 5'd0);
    imm1 = random_imm6();
    imm2 = random_imm6();
    imm3 = random_imm6();
    imm4 = random_imm6();
    imm5 = random_imm6();
    imm6 = random_imm6();
    imm7 = random_imm6();

    // Two 32-bit instructions in one packet
    begin_row(1'b1, 32'h100, {add32, addi32}, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h100, addi32, 1'b0, 1'b0);
    expect_slot(1, 32'h104, add32, 1'b0, 1'b0);
    rows.push_back(cur);
    begin_row(1'b1, 32'h200, {c_cr(1'b0, 5'd13, 5'd14), c_ci(3'b011, 5'd12, 6'h21),
              c_ci(3'b010, 5'd11, imm2), c_ci(3'b000, 5'd10, imm1)}, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h200, i_addi(sext12(imm1), 5'd10, 5'd10), 1'b1, 1'b0);
    expect_slot(1, 32'h202, i_addi(sext12(imm2), 5'd0, 5'd11), 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h204, u_lui(6'h21, 5'd12), 1'b1, 1'b0);
    expect_slot(1, 32'h206, r_add(5'd14, 5'd0, 5'd13), 1'b1, 1'b0);
    rows.push_back(cur);
    // Last parcel starts a 32-bit instruction
    begin_row(1'b1, 32'h208, {y32[15:0], c_ci(3'b000, 5'd15, imm3), 16'h0000,
              c_cr(1'b1, 5'd16, 5'd17)}, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h208, r_add(5'd17, 5'd16, 5'd16), 1'b1, 1'b0);
    expect_slot(1, 32'h20a, nop, 1'b1, 1'b1);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h20c, i_addi(sext12(imm3), 5'd15, 5'd15), 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    rows.push_back(cur);
    begin_row(1'b1, 32'h210, {c_cr(1'b1, 5'd22, 5'd23), c_cr(1'b0, 5'd19, 5'd21),
              c_ci(3'b010, 5'd18, imm4), y32[31:16]}, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h20e, y32, 1'b0, 1'b0);
    expect_slot(1, 32'h212, i_addi(sext12(imm4), 5'd0, 5'd18), 1'b1, 1'b0);
    rows.push_back(cur);
    // Back-pressure, then drain in order
    begin_row(1'b1, 32'h218, {z32, c_ci(3'b011, 5'd25, 6'h05), c_ci(3'b000, 5'd24, imm5)},
              1'b0, 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h214, r_add(5'd21, 5'd0, 5'd19), 1'b1, 1'b0);
    expect_slot(1, 32'h216, r_add(5'd23, 5'd22, 5'd22), 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h218, i_addi(sext12(imm5), 5'd24, 5'd24), 1'b1, 1'b0);
    expect_slot(1, 32'h21a, u_lui(6'h05, 5'd25), 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h21c, z32, 1'b0, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    rows.push_back(cur);
    // Fill under stall until fetch_stall rises, then clear
    data_n = {c_cr(1'b1, 5'd8, 5'd9), c_cr(1'b0, 5'd7, 5'd8), c_ci(3'b000, 5'd6, imm7),
              c_ci(3'b010, 5'd5, imm6)};
    begin_row(1'b1, 32'h300, data_n, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h300, i_addi(sext12(imm6), 5'd0, 5'd5), 1'b1, 1'b0);
    expect_slot(1, 32'h302, i_addi(sext12(imm7), 5'd6, 5'd6), 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b1, 32'h308, data_n, 1'b0, 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b1, 32'h310, data_n, 1'b0, 1'b1, 1'b0);
    rows.push_back(cur);
    begin_row(1'b1, 32'h318, data_n, 1'b0, 1'b1, 1'b1);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b1, 1'b0, 1'b0);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    rows.push_back(cur);
    // C.JR encoding is outside the subset
    begin_row(1'b1, 32'h400, {addi32, c_cr(1'b0, 5'd1, 5'd0), c_cr(1'b0, 5'd10, 5'd11)},
              1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h400, r_add(5'd11, 5'd0, 5'd10), 1'b1, 1'b0);
    expect_slot(1, 32'h402, nop, 1'b1, 1'b1);
    rows.push_back(cur);
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    expect_slot(0, 32'h404, addi32, 1'b0, 1'b0);
    rows.push_back(cur);
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_row(input row_t r, input string tag);
    logic [1:0] got_valid;
    logic [1:0] got_comp;
    logic [1:0] got_ill;
    logic [1:0][31:0] got_pc;
    logic [1:0][31:0] got_instr;
    got_valid = {issue_valid1, issue_valid0};
    got_comp = {issue_compressed1, issue_compressed0};
    got_ill = {issue_illegal1, issue_illegal0};
    got_pc = {issue_pc1, issue_pc0};
    got_instr = {issue_instr1, issue_instr0};
    check({tag, " fetch_stall"}, 32'(fetch_stall), 32'(r.exp_stall));
    for (int s = 0; s < 2; s++) begin
      check($sformatf("%s issue_valid%0d", tag, s), 32'(got_valid[s]), 32'(r.exp_valid[s]));
      check($sformatf("%s issue_instr%0d", tag, s), got_instr[s], r.exp_instr[s]);
      check($sformatf("%s issue_illegal%0d", tag, s), 32'(got_ill[s]), 32'(r.exp_ill[s]));
      if (r.exp_valid[s]) begin
        check($sformatf("%s issue_pc%0d", tag, s), got_pc[s], r.exp_pc[s]);
        check($sformatf("%s issue_compressed%0d", tag, s), 32'(got_comp[s]),
              32'(r.exp_comp[s]));
      end
    end
  endtask

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > rows.size() * 4 + 20) begin
      $display("Timeout: the run went past %0d clock cycles", rows.size() * 4 + 20);
      $display("TB FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    issue_stall = 1'b0;
    lfsr_state = 32'he23e6aa3;
    build_table();
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    begin_row(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    check_row(cur, "reset");
    for (int i = 0; i < rows.size(); i++) begin
      fetch_valid = rows[i].fetch_valid;
      fetch_pc = rows[i].fetch_pc;
      fetch_data = rows[i].fetch_data;
      clear = rows[i].clear;
      issue_stall = rows[i].issue_stall;
      @(posedge clock);
      @(negedge clock);
      check_row(rows[i], $sformatf("row %0d", i));
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic fetch_valid,
  input frontend_pkg::pc_t fetch_pc,
  input frontend_pkg::packet_t fetch_data,
  output logic fetch_stall,
  input logic issue_stall,
  output logic issue_valid0,
  output logic issue_valid1,
  output frontend_pkg::pc_t issue_pc0,
  output frontend_pkg::pc_t issue_pc1,
  output frontend_pkg::instr_t issue_instr0,
  output frontend_pkg::instr_t issue_instr1,
  output logic issue_compressed0,
  output logic issue_compressed1,
  output logic issue_illegal0,
  output logic issue_illegal1
);

  logic take;

  fetch_slot_if aligned_slots [frontend_pkg::slot_count] ();
  fetch_slot_if expanded_slots [frontend_pkg::slot_count] ();

  fetch_buffer buffer0 (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .take(take),
    .fetch_stall(fetch_stall),
    .slots(aligned_slots)
  );

  // One expander per issue slot
  for (genvar s = 0; s < frontend_pkg::slot_count; s++) begin : g_expander
    rvc_expander expander0 (
      .in(aligned_slots[s]),
      .out(expanded_slots[s])
    );
  end

  issue_register issue0 (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .issue_stall(issue_stall),
    .take(take),
    .slots(expanded_slots),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_compressed0(issue_compressed0),
    .issue_compressed1(issue_compressed1),
    .issue_illegal0(issue_illegal0),
    .issue_illegal1(issue_illegal1)
  );

endmodule

`default_nettype wire

//--- hdl/issue_register.sv
`timescale 1ns/1ns
`default_nettype none

module issue_register (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic issue_stall,
  output logic take,
  fetch_slot_if.sink slots [frontend_pkg::slot_count],
  output logic issue_valid0,
  output logic issue_valid1,
  output frontend_pkg::pc_t issue_pc0,
  output frontend_pkg::pc_t issue_pc1,
  output frontend_pkg::instr_t issue_instr0,
  output frontend_pkg::instr_t issue_instr1,
  output logic issue_compressed0,
  output logic issue_compressed1,
  output logic issue_illegal0,
  output logic issue_illegal1
);

  // Buffer only advances when the decoder accepts
  assign take = !issue_stall;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
      issue_pc0 <= '0;
      issue_pc1 <= '0;
      issue_instr0 <= rv_isa_pkg::nop_instr;
      issue_instr1 <= rv_isa_pkg::nop_instr;
      issue_compressed0 <= 1'b0;
      issue_compressed1 <= 1'b0;
      issue_illegal0 <= 1'b0;
      issue_illegal1 <= 1'b0;
    end else if (!issue_stall) begin
      issue_valid0 <= slots[0].valid;
      issue_valid1 <= slots[1].valid;
      issue_pc0 <= slots[0].pc;
      issue_pc1 <= slots[1].pc;
      issue_instr0 <= slots[0].instr;
      issue_instr1 <= slots[1].instr;
      issue_compressed0 <= slots[0].compressed;
      issue_compressed1 <= slots[1].compressed;
      issue_illegal0 <= slots[0].illegal;
      issue_illegal1 <= slots[1].illegal;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rvc_expander.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_expander (
  fetch_slot_if.sink in,
  fetch_slot_if.source out
);

  rv_isa_pkg::rvc_quadrant_e quadrant;
  rv_isa_pkg::rvc_funct3_e funct3;
  logic [4:0] rd;
  logic [4:0] rs2;
  logic [5:0] imm6;
  logic [11:0] imm12;
  frontend_pkg::instr_t expanded;
  logic unsupported;

  assign quadrant = rv_isa_pkg::rvc_quadrant_e'(in.instr[1:0]);
  assign funct3 = rv_isa_pkg::rvc_funct3_e'(in.instr[15:13]);

  // CI and CR fields
  assign rd = in.instr[11:7];
  assign rs2 = in.instr[6:2];
  assign imm6 = {in.instr[12], in.instr[6:2]};
  assign imm12 = {{6{imm6[5]}}, imm6};

  always_comb begin
    expanded = in.instr;
    unsupported = 1'b0;
    case (quadrant)
      rv_isa_pkg::q0: begin
        unsupported = 1'b1;
      end
      rv_isa_pkg::q1: begin
        case (funct3)
          rv_isa_pkg::f3_addi: begin
            expanded = {imm12, rd, rv_isa_pkg::funct3_add, rd, rv_isa_pkg::opc_op_imm};
          end
          rv_isa_pkg::f3_li: begin
            expanded = {imm12, rv_isa_pkg::reg_zero, rv_isa_pkg::funct3_add, rd,
                        rv_isa_pkg::opc_op_imm};
          end
          rv_isa_pkg::f3_lui: begin
            // Zero immediate is reserved
            if (rd == rv_isa_pkg::reg_sp || imm6 == 6'd0) begin
              unsupported = 1'b1;
            end else begin
              expanded = {{14{imm6[5]}}, imm6, rd, rv_isa_pkg::opc_lui};
            end
          end
          default: begin
            unsupported = 1'b1;
          end
        endcase
      end
      rv_isa_pkg::q2: begin
        // rs2 of zero selects jumps and breakpoints
        if (funct3 == rv_isa_pkg::f3_mv_add && rs2 != rv_isa_pkg::reg_zero) begin
          if (in.instr[12]) begin
            expanded = {7'b0, rs2, rd, rv_isa_pkg::funct3_add, rd, rv_isa_pkg::opc_op};
          end else begin
            // C.MV is add rd, x0, rs2
            expanded = {7'b0, rs2, rv_isa_pkg::reg_zero, rv_isa_pkg::funct3_add, rd,
                        rv_isa_pkg::opc_op};
          end
        end else begin
          unsupported = 1'b1;
        end
      end
      rv_isa_pkg::not_compressed: begin
        expanded = in.instr;
      end
    endcase
  end

  assign out.valid = in.valid;
  assign out.pc = in.pc;
  assign out.compressed = in.compressed;
  // An illegal flag from upstream is kept
  assign out.illegal = in.valid && (in.illegal || unsupported);
  assign out.instr = (!in.valid || in.illegal || unsupported) ? rv_isa_pkg::nop_instr
                                                              : expanded;

endmodule

`default_nettype wire

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic fetch_valid,
  input frontend_pkg::pc_t fetch_pc,
  input frontend_pkg::packet_t fetch_data,
  input logic take,
  output logic fetch_stall,
  fetch_slot_if.source slots [frontend_pkg::slot_count]
);

  frontend_pkg::parcel_t parcel_mem [frontend_pkg::buffer_depth];
  frontend_pkg::pc_t pc_mem [frontend_pkg::buffer_depth];

  frontend_pkg::ptr_t wr_ptr;
  frontend_pkg::ptr_t rd_ptr;
  frontend_pkg::count_t count;
  frontend_pkg::count_t avail;
  frontend_pkg::count_t consumed;
  frontend_pkg::count_t count_next;
  logic accept;

  // Incoming packet split into parcels
  frontend_pkg::parcel_t new_parcel [frontend_pkg::packet_parcels];
  frontend_pkg::pc_t new_pc [frontend_pkg::packet_parcels];

  // Head of the queue, stored parcels first, then the incoming packet
  frontend_pkg::parcel_t head_parcel [frontend_pkg::packet_parcels];
  frontend_pkg::pc_t head_pc [frontend_pkg::packet_parcels];

  logic comp0;
  logic comp1;
  logic [1:0] len0;
  logic [1:0] len1;

  logic slot_valid [frontend_pkg::slot_count];
  frontend_pkg::pc_t slot_pc [frontend_pkg::slot_count];
  frontend_pkg::instr_t slot_instr [frontend_pkg::slot_count];
  logic slot_comp [frontend_pkg::slot_count];

  assign accept = fetch_valid && !clear;

  always_comb begin
    for (int i = 0; i < frontend_pkg::packet_parcels; i++) begin
      new_parcel[i] = fetch_data[i*frontend_pkg::parcel_width +: frontend_pkg::parcel_width];
      new_pc[i] = fetch_pc + frontend_pkg::pc_t'(2 * i);
    end
  end

  assign avail = count + (accept ? frontend_pkg::count_t'(frontend_pkg::packet_parcels) : '0);

  always_comb begin
    logic [1:0] sel;
    for (int i = 0; i < frontend_pkg::packet_parcels; i++) begin
      sel = 2'(i - int'(count));
      if (frontend_pkg::count_t'(i) < count) begin
        head_parcel[i] = parcel_mem[rd_ptr + frontend_pkg::ptr_t'(i)];
        head_pc[i] = pc_mem[rd_ptr + frontend_pkg::ptr_t'(i)];
      end else begin
        head_parcel[i] = new_parcel[sel];
        head_pc[i] = new_pc[sel];
      end
    end
  end

  // Slot 0 starts at the head, slot 1 right after it
  assign comp0 = ~&head_parcel[0][1:0];
  assign len0 = comp0 ? 2'd1 : 2'd2;
  assign comp1 = ~&head_parcel[len0][1:0];
  assign len1 = comp1 ? 2'd1 : 2'd2;

  always_comb begin
    slot_valid[0] = (avail >= 1) && (comp0 || avail >= 2);
    slot_pc[0] = head_pc[0];
    slot_comp[0] = comp0;
    if (comp0) begin
      slot_instr[0] = {{frontend_pkg::parcel_width{1'b0}}, head_parcel[0]};
    end else begin
      slot_instr[0] = {head_parcel[1], head_parcel[0]};
    end

    // Upper half of a 32-bit instruction may still be missing
    slot_valid[1] = slot_valid[0] && (avail > frontend_pkg::count_t'(len0))
                    && (comp1 || avail > frontend_pkg::count_t'(len0) + 1);
    slot_pc[1] = head_pc[len0];
    slot_comp[1] = comp1;
    if (comp1) begin
      slot_instr[1] = {{frontend_pkg::parcel_width{1'b0}}, head_parcel[len0]};
    end else begin
      slot_instr[1] = {head_parcel[len0 + 2'd1], head_parcel[len0]};
    end
  end

  always_comb begin
    consumed = '0;
    if (take) begin
      if (slot_valid[0]) begin
        consumed = consumed + frontend_pkg::count_t'(len0);
      end
      if (slot_valid[1]) begin
        consumed = consumed + frontend_pkg::count_t'(len1);
      end
    end
  end

  assign count_next = avail - consumed;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      fetch_stall <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + frontend_pkg::ptr_t'(frontend_pkg::packet_parcels);
      end
      rd_ptr <= rd_ptr + frontend_pkg::ptr_t'(consumed);
      count <= count_next;
      fetch_stall <= count_next > frontend_pkg::count_t'(frontend_pkg::stall_level);
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int i = 0; i < frontend_pkg::packet_parcels; i++) begin
        parcel_mem[wr_ptr + frontend_pkg::ptr_t'(i)] <= new_parcel[i];
        pc_mem[wr_ptr + frontend_pkg::ptr_t'(i)] <= new_pc[i];
      end
    end
  end

  for (genvar s = 0; s < frontend_pkg::slot_count; s++) begin : g_slot
    assign slots[s].valid = slot_valid[s];
    assign slots[s].pc = slot_pc[s];
    assign slots[s].instr = slot_instr[s];
    assign slots[s].compressed = slot_comp[s];
    // Legality is judged by the expander
    assign slots[s].illegal = 1'b0;
  end

endmodule

`default_nettype wire

//--- hdl/fetch_slot_if.sv
`timescale 1ns/1ns
`default_nettype none

// One issue slot between front end stages
interface fetch_slot_if ();

  logic valid;
  frontend_pkg::pc_t pc;
  frontend_pkg::instr_t instr;
  logic compressed;
  logic illegal;

  modport source (
    output valid,
    output pc,
    output instr,
    output compressed,
    output illegal
  );

  modport sink (
    input valid,
    input pc,
    input instr,
    input compressed,
    input illegal
  );

endinterface

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Quadrant from instruction bits 1:0
  typedef enum logic [1:0] {
    q0 = 2'b00,
    q1 = 2'b01,
    q2 = 2'b10,
    not_compressed = 2'b11
  } rvc_quadrant_e;

  // Supported funct3 codes, bits 15:13
  typedef enum logic [2:0] {
    f3_addi = 3'b000,
    f3_li = 3'b010,
    f3_lui = 3'b011,
    f3_mv_add = 3'b100
  } rvc_funct3_e;

  // Base opcodes produced by the expander
  typedef enum logic [6:0] {
    opc_op_imm = 7'b0010011,
    opc_lui = 7'b0110111,
    opc_op = 7'b0110011
  } opcode_e;

  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [4:0] reg_zero = 5'd0;
  // x2, where C.LUI encodes C.ADDI16SP instead
  localparam logic [4:0] reg_sp = 5'd2;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

//--- hdl/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  // Front end geometry
  localparam int parcel_width = 16;
  localparam int packet_parcels = 4;
  localparam int buffer_depth = 16;
  localparam int stall_level = 12;
  localparam int slot_count = 2;
  localparam int pc_width = 32;

  // Derived widths
  localparam int instr_width = 2 * parcel_width;
  localparam int packet_width = packet_parcels * parcel_width;
  localparam int ptr_width = $clog2(buffer_depth);
  localparam int count_width = $clog2(buffer_depth + packet_parcels + 1);

  typedef logic [parcel_width-1:0] parcel_t;
  typedef logic [instr_width-1:0] instr_t;
  typedef logic [packet_width-1:0] packet_t;
  typedef logic [pc_width-1:0] pc_t;
  typedef logic [ptr_width-1:0] ptr_t;
  // Wide enough for a full buffer plus one incoming packet
  typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire
